// ==== common/fpuEx_params.svh ====
//##########################################################
// fpu execute widths
// word, command field and IEEE-754 field sizes
//##########################################################
`ifndef FPU_EX_PARAMS_SVH
`define FPU_EX_PARAMS_SVH

`define FPU_WORD_W 64 // register / operand width
`define FPU_SGL_W 32 // single precision
`define UCMD_W 6 // micro-command, cmd[5:0]
`define CC_W 2 // condition code, cmd[7:6]
`define IXT_W 8 // opcode extension byte

`define DBL_EXP_W 11
`define SGL_EXP_W 8
`define DBL_MAN_W 52
`define SGL_MAN_W 23
`define EXP_REBIAS 896 // 1023 - 127

`endif

// ==== common/fpuOpcode_pkg.sv ====
//##########################################################
// fpu opcode package
// micro-commands, condition codes, sub-operations
//##########################################################
`include "fpuEx_params.svh"

package fpuOpcode_pkg;

	// micro-commands handled by the fpu slave
	typedef enum logic [`UCMD_W-1:0] {
		UCMD_NOP = 6'h00,
		UCMD_FCMP = 6'h14, // compare, drives T
		UCMD_FLDCX = 6'h15, // load convert, widen
		UCMD_FSTCX = 6'h16, // store convert, narrow
		UCMD_FIXS = 6'h17 // sign fixups
	} fpuUcmd_e;

	typedef enum logic [`CC_W-1:0] {
		COND_AL = 2'd0, // always
		COND_NV = 2'd1, // never
		COND_CT = 2'd2, // if T set
		COND_CF = 2'd3 // if T clear
	} fpuCond_e;

	// ixt[2:0], ixt[3] picks the Rs half
	typedef enum logic [2:0] {LDCX_S2D = 3'd0, LDCX_MOV = 3'd1} fpuLdcxOp_e;

	typedef enum logic [3:0] {STCX_D2S = 4'd0, STCX_MOV = 4'd1} fpuStcxOp_e;

	typedef enum logic [3:0] {CMP_EQ = 4'd0, CMP_GT = 4'd1} fpuCmpOp_e;

	typedef enum logic [3:0] {FIX_NEG = 4'd0, FIX_ABS = 4'd1} fpuFixOp_e;

endpackage

// ==== common/fpuFormat_pkg.sv ====
//##########################################################
// fpu format package
// execute status and IEEE-754 field views
//##########################################################
`include "fpuEx_params.svh"

package fpuFormat_pkg;

	// every op is single cycle, no hold state
	typedef enum logic [1:0] {
		STATUS_READY = 2'd0, // idle or disabled
		STATUS_OK = 2'd1 // command executed
	} fpuStatus_e;

	typedef struct packed {
		logic sign;
		logic [`DBL_EXP_W-1:0] exp;
		logic [`DBL_MAN_W-1:0] man;
	} fpuDouble_t;

	typedef struct packed {
		logic sign;
		logic [`SGL_EXP_W-1:0] exp;
		logic [`SGL_MAN_W-1:0] man;
	} fpuSingle_t;

endpackage

// ==== source/fpuLaneSelect.sv ====
//##########################################################
// fpu lane select
// picks lane A or B and latches the issued command
//##########################################################
`timescale 1ns/1ns
`include "fpuEx_params.svh"

module fpuLaneSelect
	import fpuOpcode_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic exHold,
	input logic braFlush,
	input logic [7:0] opCmdA,
	input logic [7:0] opCmdB,
	input logic [`IXT_W-1:0] ixtA,
	input logic [`IXT_W-1:0] ixtB,
	input logic [`FPU_WORD_W-1:0] regValRsA,
	input logic [`FPU_WORD_W-1:0] regValRtA,
	input logic [`FPU_WORD_W-1:0] regValRsB,
	input logic [`FPU_WORD_W-1:0] regValRtB,
	output logic [7:0] issueCmd,
	output logic [`IXT_W-1:0] issueIxt,
	output logic [`FPU_WORD_W-1:0] issueRs,
	output logic [`FPU_WORD_W-1:0] issueRt,
	output logic issueFlush
);

	logic laneA, laneB; // lane carries an fpu command
	logic [7:0] nextCmd;

	function automatic logic isFpuCmd(input logic [7:0] cmd);
		fpuUcmd_e uCmd;
		uCmd = fpuUcmd_e'(cmd[`UCMD_W-1:0]);
		return uCmd inside {UCMD_FCMP, UCMD_FLDCX, UCMD_FSTCX, UCMD_FIXS};
	endfunction

	assign laneA = isFpuCmd(opCmdA);
	assign laneB = isFpuCmd(opCmdB) && !laneA; // A has priority

	always_comb begin
		if (laneA)
			nextCmd = opCmdA;
		else if (laneB)
			nextCmd = opCmdB;
		else
			nextCmd = {COND_AL, UCMD_NOP}; // nothing for us
	end

	// control part of the latch
	always_ff @(posedge clock) begin
		if (reset) begin
			issueCmd <= {COND_AL, UCMD_NOP};
			issueFlush <= 1'b0;
		end else if (!exHold) begin
			issueCmd <= nextCmd;
			issueFlush <= braFlush;
		end
	end

	// operands, lane A unless B won
	always_ff @(posedge clock) begin
		if (!exHold) begin
			issueIxt <= laneB ? ixtB : ixtA;
			issueRs <= laneB ? regValRsB : regValRsA;
			issueRt <= laneB ? regValRtB : regValRtA;
		end
	end

endmodule

// ==== convert/fpuConvS2D.sv ====
//##########################################################
// single to double conversion
// zero/subnormal inputs flush to signed zero
//##########################################################
`timescale 1ns/1ns
`include "fpuEx_params.svh"

module fpuConvS2D
	import fpuFormat_pkg::*;
(
	input fpuSingle_t sglIn,
	output fpuDouble_t dblOut
);

	localparam int manPad = `DBL_MAN_W - `SGL_MAN_W; // 29 low zero bits
	localparam int expPad = `DBL_EXP_W - `SGL_EXP_W;
	localparam logic [`DBL_EXP_W-1:0] rebias = `EXP_REBIAS;

	logic expZero; // zero or subnormal
	logic expMax; // inf or nan

	assign expZero = (sglIn.exp == '0);
	assign expMax = &sglIn.exp;

	always_comb begin
		dblOut.sign = sglIn.sign; // sign always kept
		dblOut.man = {sglIn.man, {manPad{1'b0}}};
		if (expZero) begin
			dblOut.exp = '0;
			dblOut.man = '0; // subnormals dropped
		end else if (expMax) begin
			dblOut.exp = '1; // nan payload rides in man
		end else begin
			dblOut.exp = {{expPad{1'b0}}, sglIn.exp} + rebias;
		end
	end

endmodule

// ==== convert/fpuConvD2S.sv ====
//##########################################################
// double to single conversion
// truncating, out-of-range saturates to inf or zero
//##########################################################
`timescale 1ns/1ns
`include "fpuEx_params.svh"

module fpuConvD2S
	import fpuFormat_pkg::*;
(
	input fpuDouble_t dblIn,
	output fpuSingle_t sglOut
);

	localparam logic [`DBL_EXP_W+1:0] rebias = `EXP_REBIAS;
	localparam int sglExpMax = (1 << `SGL_EXP_W) - 2; // 254, largest finite

	logic signed [`DBL_EXP_W+1:0] rebExp; // two guard bits for under/overflow
	logic isSpecial, isNan;

	assign rebExp = {2'b00, dblIn.exp} - rebias;
	assign isSpecial = &dblIn.exp;
	assign isNan = isSpecial && (dblIn.man != '0);

	always_comb begin
		sglOut.sign = dblIn.sign;
		sglOut.exp = rebExp[`SGL_EXP_W-1:0];
		sglOut.man = dblIn.man[`DBL_MAN_W-1 -: `SGL_MAN_W]; // top 23, toward zero
		if (isNan) begin
			sglOut.exp = '1;
			// quiet bit forced so payload never collapses to inf
			sglOut.man = {1'b1, dblIn.man[`DBL_MAN_W-2 -: (`SGL_MAN_W-1)]};
		end else if (isSpecial) begin
			sglOut.exp = '1; // inf
			sglOut.man = '0;
		end else if (rebExp > sglExpMax) begin
			sglOut.exp = '1; // overflow to inf
			sglOut.man = '0;
		end else if (rebExp < 1) begin
			sglOut.exp = '0; // underflow, also dbl zero/denorm
			sglOut.man = '0;
		end
	end

endmodule

// ==== source/fpuCompare.sv ====
//##########################################################
// double compare
// EQ / GT in signed magnitude, nan never compares true
//##########################################################
`timescale 1ns/1ns

module fpuCompare
	import fpuFormat_pkg::*, fpuOpcode_pkg::*;
(
	input fpuDouble_t rs,
	input fpuDouble_t rt,
	input fpuCmpOp_e cmpOp,
	output logic cmpT
);

	logic rsNan, rtNan;
	logic bothZero; // +0 and -0 are equal
	logic isEq, isGt;
	logic magGt, magLt;

	assign rsNan = (&rs.exp) && (rs.man != '0);
	assign rtNan = (&rt.exp) && (rt.man != '0);
	assign bothZero = ({rs.exp, rs.man} == '0) && ({rt.exp, rt.man} == '0);

	assign magGt = {rs.exp, rs.man} > {rt.exp, rt.man};
	assign magLt = {rs.exp, rs.man} < {rt.exp, rt.man};

	assign isEq = (rs == rt) || bothZero;

	always_comb begin
		if (bothZero)
			isGt = 1'b0;
		else if (rs.sign != rt.sign)
			isGt = !rs.sign; // positive beats negative
		else if (!rs.sign)
			isGt = magGt;
		else
			isGt = magLt; // both negative, reversed
	end

	always_comb begin
		cmpT = 1'b0;
		if (!rsNan && !rtNan) begin
			case (cmpOp)
				CMP_EQ: cmpT = isEq;
				CMP_GT: cmpT = isGt;
				default: cmpT = 1'b0; // unknown op reads as false
			endcase
		end
	end

endmodule

// ==== source/fpuExOpW.sv ====
//##########################################################
// fpu execute slave, scalar datapath
// lane pick, condition gating, convert / compare / sign ops
//##########################################################
`timescale 1ns/1ns
`include "fpuEx_params.svh"

module fpuExOpW
	import fpuOpcode_pkg::*, fpuFormat_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [7:0] opCmdA, // [7:6] cc, [5:0] ucmd
	input logic [7:0] opCmdB,
	input logic [`IXT_W-1:0] ixtA, // [3:0] sub-op
	input logic [`IXT_W-1:0] ixtB,
	input logic [`FPU_WORD_W-1:0] regValRsA,
	input logic [`FPU_WORD_W-1:0] regValRtA,
	input logic [`FPU_WORD_W-1:0] regValRsB,
	input logic [`FPU_WORD_W-1:0] regValRtB,
	input logic [`FPU_WORD_W-1:0] regInSr, // bit 0 is T
	input logic braFlush,
	input logic exHold,
	output logic [`FPU_WORD_W-1:0] regValGRn,
	output logic regOutSrT,
	output fpuStatus_e regOutOK
);

	logic [7:0] issueCmd;
	logic [`IXT_W-1:0] issueIxt;
	logic [`FPU_WORD_W-1:0] issueRs, issueRt;
	logic issueFlush;

	fpuCond_e cond;
	fpuUcmd_e uCmd;
	logic opEnable;

	fpuSingle_t s2dIn;
	fpuDouble_t s2dOut, d2sIn, cmpRs, cmpRt;
	fpuSingle_t d2sOut;
	logic cmpT;

	fpuLaneSelect u_laneSelect (
		.clock(clock), .reset(reset), .exHold(exHold), .braFlush(braFlush),
		.opCmdA(opCmdA), .opCmdB(opCmdB), .ixtA(ixtA), .ixtB(ixtB),
		.regValRsA(regValRsA), .regValRtA(regValRtA),
		.regValRsB(regValRsB), .regValRtB(regValRtB),
		.issueCmd(issueCmd), .issueIxt(issueIxt),
		.issueRs(issueRs), .issueRt(issueRt), .issueFlush(issueFlush)
	);

	assign cond = fpuCond_e'(issueCmd[7 -: `CC_W]);
	assign uCmd = fpuUcmd_e'(issueCmd[`UCMD_W-1:0]);

	// ixt[3] picks the upper single
	assign s2dIn = issueIxt[3] ? issueRs[`FPU_WORD_W-1 -: `FPU_SGL_W]
		: issueRs[`FPU_SGL_W-1:0];
	assign d2sIn = issueRs;
	assign cmpRs = issueRs;
	assign cmpRt = issueRt;

	fpuConvS2D u_convS2D (.sglIn(s2dIn), .dblOut(s2dOut));

	fpuConvD2S u_convD2S (.dblIn(d2sIn), .sglOut(d2sOut));

	fpuCompare u_compare (
		.rs(cmpRs), .rt(cmpRt), .cmpOp(fpuCmpOp_e'(issueIxt[3:0])), .cmpT(cmpT)
	);

	// flush kills the command, else the cc against current T
	always_comb begin
		if (issueFlush)
			opEnable = 1'b0;
		else begin
			case (cond)
				COND_AL: opEnable = 1'b1;
				COND_NV: opEnable = 1'b0;
				COND_CT: opEnable = regInSr[0];
				default: opEnable = !regInSr[0]; // CF
			endcase
		end
	end

	always_comb begin
		regValGRn = '0;
		regOutSrT = regInSr[0]; // T passes through by default
		regOutOK = STATUS_READY;
		if (opEnable) begin
			case (uCmd)
				UCMD_FCMP: begin
					regOutSrT = cmpT;
					regOutOK = STATUS_OK;
				end
				UCMD_FLDCX: begin
					regOutOK = STATUS_OK;
					case (fpuLdcxOp_e'(issueIxt[2:0]))
						LDCX_S2D: regValGRn = s2dOut;
						LDCX_MOV: regValGRn = issueRs; // raw move
						default: regValGRn = '0;
					endcase
				end
				UCMD_FSTCX: begin
					regOutOK = STATUS_OK;
					case (fpuStcxOp_e'(issueIxt[3:0]))
						STCX_D2S: regValGRn = {{(`FPU_WORD_W-`FPU_SGL_W){1'b0}}, d2sOut};
						STCX_MOV: regValGRn = issueRs;
						default: regValGRn = '0;
					endcase
				end
				UCMD_FIXS: begin
					regOutOK = STATUS_OK;
					case (fpuFixOp_e'(issueIxt[3:0]))
						FIX_NEG: regValGRn = {~issueRs[`FPU_WORD_W-1], issueRs[`FPU_WORD_W-2:0]};
						FIX_ABS: regValGRn = {1'b0, issueRs[`FPU_WORD_W-2:0]};
						default: regValGRn = '0;
					endcase
				end
				default: begin
					// NOP, stays READY
				end
			endcase
		end
	end

endmodule

// ==== verification/fpuExOpW_asserts.sv ====
//##########################################################
// fpuExOpW checker
// reference issue latch, gating and result rules,
// bound into the DUT
//##########################################################
`timescale 1ns/1ns
`include "fpuEx_params.svh"

module fpuExOpW_asserts
	import fpuFormat_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [7:0] opCmdA,
	input logic [7:0] opCmdB,
	input logic [`IXT_W-1:0] ixtA,
	input logic [`IXT_W-1:0] ixtB,
	input logic [`FPU_WORD_W-1:0] regValRsA,
	input logic [`FPU_WORD_W-1:0] regValRtA,
	input logic [`FPU_WORD_W-1:0] regValRsB,
	input logic [`FPU_WORD_W-1:0] regValRtB,
	input logic [`FPU_WORD_W-1:0] regInSr,
	input logic braFlush,
	input logic exHold,
	input logic [`FPU_WORD_W-1:0] regValGRn,
	input logic regOutSrT,
	input fpuStatus_e regOutOK
);

	int failCount = 0; // read by the testbench
	string failTest = "";
	logic [`FPU_WORD_W-1:0] failExp, failAct;

	logic [7:0] refCmd; // reference issue latch
	logic [`IXT_W-1:0] refIxt;
	logic [`FPU_WORD_W-1:0] refRs, refRt;
	logic refFlush;
	logic [`FPU_WORD_W-1:0] lastResult; // output one cycle back

	logic enable;
	logic [`FPU_WORD_W-1:0] expResult;
	logic expT;
	fpuStatus_e expOk;

	// FCMP .. FIXS
	function automatic logic fpuLane(input logic [7:0] cmd);
		return (cmd[5:0] >= 6'h14) && (cmd[5:0] <= 6'h17);
	endfunction

	function automatic logic [63:0] widen(input logic [31:0] s);
		logic [10:0] e;
		e = {3'b000, s[30:23]} + 11'(`EXP_REBIAS);
		if (s[30:23] == 8'h00)
			return {s[31], 63'd0}; // zero, subnormal flushed
		if (s[30:23] == 8'hff)
			return {s[31], 11'h7ff, s[22:0], 29'd0}; // inf / nan payload
		return {s[31], e, s[22:0], 29'd0};
	endfunction

	function automatic logic [31:0] narrow(input logic [63:0] d);
		int e;
		e = int'(d[62:52]) - `EXP_REBIAS;
		if (d[62:52] == 11'h7ff)
			return (d[51:0] != '0) ? {d[63], 8'hff, 1'b1, d[50:29]} : {d[63], 8'hff, 23'd0};
		if (e > 254)
			return {d[63], 8'hff, 23'd0}; // too big
		if (e < 1)
			return {d[63], 31'd0}; // too small
		return {d[63], e[7:0], d[51:29]}; // chop low mantissa
	endfunction

	// sign-magnitude mapped onto a signed line, -0 lands on 0
	function automatic logic signed [63:0] orderKey(input logic [63:0] d);
		logic signed [63:0] mag;
		mag = {1'b0, d[62:0]};
		return d[63] ? -mag : mag;
	endfunction

	function automatic logic compareRef(input logic [63:0] a, input logic [63:0] b,
		input logic [3:0] op);
		logic nan;
		nan = ((a[62:52] == 11'h7ff) && (a[51:0] != '0))
			|| ((b[62:52] == 11'h7ff) && (b[51:0] != '0));
		if (nan)
			return 1'b0;
		if (op == 4'd0)
			return orderKey(a) == orderKey(b);
		if (op == 4'd1)
			return orderKey(a) > orderKey(b);
		return 1'b0; // unknown compare
	endfunction

	task automatic logFailure(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		failTest = name;
		failExp = exp;
		failAct = act;
		failCount++;
	endtask

	always_ff @(posedge clock) begin
		lastResult <= regValGRn;
		if (reset) begin
			refCmd <= 8'h00;
			refFlush <= 1'b0;
			refIxt <= '0;
			refRs <= '0;
			refRt <= '0;
		end else if (!exHold) begin
			refFlush <= braFlush;
			if (fpuLane(opCmdA)) begin
				refCmd <= opCmdA;
				refIxt <= ixtA;
				refRs <= regValRsA;
				refRt <= regValRtA;
			end else if (fpuLane(opCmdB)) begin
				refCmd <= opCmdB;
				refIxt <= ixtB;
				refRs <= regValRsB;
				refRt <= regValRtB;
			end else
				refCmd <= 8'h00; // nothing issued
		end
	end

	always_comb begin
		case (refCmd[7:6])
			2'd0: enable = 1'b1;
			2'd1: enable = 1'b0;
			2'd2: enable = regInSr[0];
			default: enable = !regInSr[0];
		endcase
		if (refFlush)
			enable = 1'b0;
		expResult = '0;
		expT = regInSr[0];
		expOk = (enable && fpuLane(refCmd)) ? STATUS_OK : STATUS_READY;
		if (enable) begin
			case (refCmd[5:0])
				6'h14: expT = compareRef(refRs, refRt, refIxt[3:0]);
				6'h15: begin
					if (refIxt[2:0] == 3'd0)
						expResult = widen(refIxt[3] ? refRs[63:32] : refRs[31:0]);
					else if (refIxt[2:0] == 3'd1)
						expResult = refRs;
				end
				6'h16: begin
					if (refIxt[3:0] == 4'd0)
						expResult = {32'd0, narrow(refRs)}; // zero-extended
					else if (refIxt[3:0] == 4'd1)
						expResult = refRs;
				end
				6'h17: begin
					if (refIxt[3:0] == 4'd0)
						expResult = refRs ^ {1'b1, 63'd0};
					else if (refIxt[3:0] == 4'd1)
						expResult = refRs & {1'b0, {63{1'b1}}};
				end
				default: ;
			endcase
		end
	end

	resultChk: assert property (@(posedge clock) disable iff (reset) regValGRn == expResult)
		else begin
			logFailure("result", $sampled(expResult), $sampled(regValGRn));
			$error("result differs from the reference");
		end

	flagChk: assert property (@(posedge clock) disable iff (reset) regOutSrT == expT)
		else begin
			logFailure("tFlag", 64'($sampled(expT)), 64'($sampled(regOutSrT)));
			$error("T flag differs from the reference");
		end

	statusChk: assert property (@(posedge clock) disable iff (reset) regOutOK == expOk)
		else begin
			logFailure("status", 64'($sampled(expOk)), 64'($sampled(regOutOK)));
			$error("status differs from the reference");
		end

	// held latch, same T, so the result must not move
	holdChk: assert property (@(posedge clock) disable iff (reset)
		$past(exHold) && $stable(regInSr[0]) |-> $stable(regValGRn))
		else begin
			logFailure("hold", $sampled(lastResult), $sampled(regValGRn));
			$error("result changed while exHold was high");
		end

endmodule

bind fpuExOpW fpuExOpW_asserts i_asserts (.*);

// ==== verification/fpuExOpW_tb.sv ====
//##########################################################
// fpuExOpW testbench
// LFSR and directed stimulus, bound assertions check
//##########################################################
`timescale 1ns/1ns
`include "fpuEx_params.svh"

module fpuExOpW_tb
	import fpuOpcode_pkg::*, fpuFormat_pkg::*;
();

	logic clock, reset;
	logic [7:0] opCmdA, opCmdB;
	logic [`IXT_W-1:0] ixtA, ixtB;
	logic [`FPU_WORD_W-1:0] regValRsA, regValRtA, regValRsB, regValRtB;
	logic [`FPU_WORD_W-1:0] regInSr;
	logic braFlush, exHold;
	logic [`FPU_WORD_W-1:0] regValGRn;
	logic regOutSrT;
	fpuStatus_e regOutOK;

	logic [31:0] lfsr;
	logic tBit, flushBit; // T and flush for the next issue
	logic [63:0] w, v;
	string phase;
	logic [63:0] dblSpecial [12];
	logic [31:0] sglSpecial [8];

	fpuExOpW i_fpuExOpW (
		.clock(clock), .reset(reset),
		.opCmdA(opCmdA), .opCmdB(opCmdB), .ixtA(ixtA), .ixtB(ixtB),
		.regValRsA(regValRsA), .regValRtA(regValRtA),
		.regValRsB(regValRsB), .regValRtB(regValRtB),
		.regInSr(regInSr), .braFlush(braFlush), .exHold(exHold),
		.regValGRn(regValGRn), .regOutSrT(regOutSrT), .regOutOK(regOutOK)
	);

	always #5 clock = ~clock;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic stepLfsr();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] randWord(input int nBits);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < nBits; i++)
			r = {r[62:0], stepLfsr()}; // one step per bit
		return r;
	endfunction

	function automatic logic [7:0] cmdOf(input fpuCond_e cc, input fpuUcmd_e u);
		return {cc, u};
	endfunction

	task automatic abortRun(input string reason);
		$display("CHECKS FAILED");
		$fatal(1, "%s", reason);
	endtask

	// one command on the chosen lane, noise on the other
	task automatic issue(input logic useB, input logic [7:0] cmd, input logic [7:0] ixt,
		input logic [63:0] rs, input logic [63:0] rt);
		logic [7:0] noise;
		noise = 8'(randWord(8));
		@(posedge clock);
		opCmdA <= useB ? {noise[7:6], 2'b00, noise[3:0]} : cmd; // idle A is never fpu
		opCmdB <= useB ? cmd : {noise[7:6], 2'b01, noise[3:0]}; // often fpu, A must win
		ixtA <= useB ? noise : ixt;
		ixtB <= useB ? ixt : noise;
		regValRsA <= useB ? randWord(64) : rs;
		regValRtA <= useB ? randWord(64) : rt;
		regValRsB <= useB ? rs : randWord(64);
		regValRtB <= useB ? rt : randWord(64);
		regInSr <= (randWord(64) & ~64'h1) | {63'd0, tBit};
		braFlush <= flushBit;
		exHold <= 1'b0;
	endtask

	task automatic waitIdle(input string what, input int limit);
		int cyc;
		cyc = 0;
		while (regOutOK != STATUS_READY) begin
			if (cyc == limit)
				abortRun({"timeout waiting for ", what, " to go idle"});
			else begin
				cyc++;
				@(negedge clock);
			end
		end
	endtask

	task automatic drain(input string what);
		@(posedge clock);
		opCmdA <= 8'h00;
		opCmdB <= 8'h00;
		braFlush <= 1'b0;
		exHold <= 1'b0;
		@(negedge clock);
		waitIdle(what, 4);
	endtask

	// first failing assertion ends the run
	always @(i_fpuExOpW.i_asserts.failCount) begin
		if (i_fpuExOpW.i_asserts.failCount != 0) begin
			$display("[ERROR] %s/%s expected %h actual %h", phase,
				i_fpuExOpW.i_asserts.failTest, i_fpuExOpW.i_asserts.failExp,
				i_fpuExOpW.i_asserts.failAct);
			abortRun("a checker assertion failed");
		end
	end

	initial begin
		lfsr = 32'hf49b_8fe6;
		clock = 1'b0;
		reset = 1'b1;
		exHold = 1'b0;
		braFlush = 1'b0;
		opCmdA = 8'h00;
		opCmdB = 8'h00;
		ixtA = '0;
		ixtB = '0;
		regValRsA = '0;
		regValRtA = '0;
		regValRsB = '0;
		regValRtB = '0;
		regInSr = 64'h1; // T set through reset
		tBit = 1'b0;
		flushBit = 1'b0;
		phase = "reset";
		// zeros, infinities, nans, single exponent edges, 1.0, denormal
		dblSpecial = '{64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000,
			64'h7ff0_0000_0000_0000, 64'hfff0_0000_0000_0000,
			64'h7ff8_0000_0000_0000, 64'h7ff0_0000_0000_0001,
			64'h47ef_ffff_ffff_ffff, 64'hc7f0_0000_0000_0001,
			64'h3810_0000_0000_0000, 64'hb80f_ffff_ffff_ffff,
			64'h3ff0_0000_0000_0000, 64'h0000_0000_0000_0001};
		sglSpecial = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,
			32'h7fc0_0000, 32'h0000_0001, 32'h3f80_0000, 32'hff7f_ffff};

		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		waitIdle("reset release", 4);

		phase = "lanes";
		for (int i = 0; i < 32; i++) begin
			tBit = randWord(1) != 0;
			flushBit = (i % 5 == 4); // every fifth issue flushed
			issue(i[0], cmdOf(fpuCond_e'(i[2:1]), i[3] ? UCMD_FIXS : UCMD_FLDCX),
				{7'd0, i[4]}, randWord(64), randWord(64));
		end
		flushBit = 1'b0;
		repeat (3)
			issue(1'b1, 8'h05, 8'h00, randWord(64), randWord(64)); // no fpu lane
		drain("lanes");

		phase = "convert";
		for (int i = 0; i < 40; i++) begin
			w = (i < 8) ? {sglSpecial[i], sglSpecial[7-i]} : randWord(64);
			issue(i[0], cmdOf(COND_AL, UCMD_FLDCX), 8'h00, w, randWord(64)); // low half
			issue(i[0], cmdOf(COND_AL, UCMD_FLDCX), 8'h08, w, randWord(64)); // high half
			issue(i[0], cmdOf(COND_AL, UCMD_FLDCX), {4'h0, i[1], 3'd1}, w, randWord(64));
		end
		for (int i = 0; i < 40; i++) begin
			w = (i < 12) ? dblSpecial[i] : randWord(64);
			issue(i[0], cmdOf(COND_AL, UCMD_FSTCX), 8'h00, w, randWord(64));
			issue(i[0], cmdOf(COND_AL, UCMD_FSTCX), 8'h01, w, randWord(64));
		end
		issue(1'b0, cmdOf(COND_AL, UCMD_FSTCX), 8'h05, randWord(64), randWord(64));
		drain("convert");

		phase = "compare";
		for (int i = 0; i < 12; i++) begin
			for (int j = 0; j < 12; j++) begin
				issue(j[0], cmdOf(COND_AL, UCMD_FCMP), 8'h00, dblSpecial[i], dblSpecial[j]);
				issue(j[0], cmdOf(COND_AL, UCMD_FCMP), 8'h01, dblSpecial[i], dblSpecial[j]);
			end
		end
		for (int i = 0; i < 48; i++) begin
			tBit = randWord(1) != 0;
			w = randWord(64);
			v = (i % 3 == 0) ? w : ((i % 3 == 1) ? w ^ {1'b1, 63'd0} : randWord(64));
			issue(i[0], cmdOf(fpuCond_e'(2'(randWord(2))), UCMD_FCMP), {7'd0, i[1]}, w, v);
		end
		drain("compare");

		phase = "fixs";
		for (int i = 0; i < 24; i++) begin
			w = (i < 12) ? dblSpecial[i] : randWord(64);
			issue(i[0], cmdOf(COND_AL, UCMD_FIXS), 8'h00, w, randWord(64));
			issue(i[0], cmdOf(COND_AL, UCMD_FIXS), 8'h01, w, randWord(64));
		end
		issue(1'b1, cmdOf(COND_AL, UCMD_FIXS), 8'h07, randWord(64), randWord(64));
		drain("fixs");

		phase = "hold";
		for (int k = 0; k < 4; k++) begin
			issue(k[0], cmdOf(COND_AL, fpuUcmd_e'(6'h14 + 6'(k))), {7'd0, k[1]},
				dblSpecial[k+4], randWord(64));
			@(posedge clock);
			exHold <= 1'b1; // latched command frozen from here
			for (int i = 0; i < 6; i++) begin
				@(posedge clock);
				opCmdA <= 8'(randWord(8));
				opCmdB <= 8'(randWord(8));
				regValRsA <= randWord(64);
				regValRsB <= randWord(64);
				braFlush <= randWord(1) != 0;
			end
			@(posedge clock);
			exHold <= 1'b0;
		end
		drain("hold");

		if (i_fpuExOpW.i_asserts.failCount != 0)
			abortRun("checker assertions failed during the run");
		else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// ==== sources.f ====
+incdir+common
common/fpuOpcode_pkg.sv
common/fpuFormat_pkg.sv
source/fpuLaneSelect.sv
convert/fpuConvS2D.sv
convert/fpuConvD2S.sv
source/fpuCompare.sv
source/fpuExOpW.sv
verification/fpuExOpW_asserts.sv
verification/fpuExOpW_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP := fpuExOpW_tb
FILELIST := sources.f
BUILD_DIR := obj_dir
FLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
RUN_FLAGS := +verilator+error+limit+1000
LOG := sim.log
PASS_MSG := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
